// File: csa_tree_pkg.sv
`default_nettype none

package csa_tree_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Default sizes
    ////////////////////////////////////////////////////////////////////////////

    parameter int DEF_DATA_W = 8;  // Operand width
    parameter int DEF_DATA_N = 8;  // Operand count, kept even

    // Latency of the merge block, 4:2 level plus final add
    parameter int MERGE_STAGES = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Elaboration helpers
    ////////////////////////////////////////////////////////////////////////////

    // Words left after one 3:2 level
    function automatic int csa_level_outputs(input int m);
        int groups;
        int rest;
        groups = m / 3;
        rest   = m % 3;
        return groups * 2 + rest;  // Two words per group, leftovers pass
    endfunction

    // Number of 3:2 levels until exactly two words remain
    function automatic int csa_stage_count(input int n);
        int cnt;
        int left;
        cnt  = 0;
        left = n;
        while (left > 2) begin
            left = csa_level_outputs(left);
            cnt  = cnt + 1;
        end
        return cnt;
    endfunction

    // Result width that holds the sum of n words of w bits
    function automatic int csa_out_width(input int w, input int n);
        int extra;
        int span;
        extra = 0;
        span  = 1;
        while (span < n) begin  // Ceiling of log2
            span  = span * 2;
            extra = extra + 1;
        end
        return w + extra;
    endfunction

endpackage

`default_nettype wire

// File: csa_level.sv
`default_nettype none

// One registered level of 3:2 compressors
module csa_level #(
    parameter int P_WIDTH = 8,
    parameter int P_IN_N  = 3
) (
    input  logic                                                        clk,
    input  logic                                                        i_rst,
    input  logic [P_IN_N-1:0][P_WIDTH-1:0]                              i_ops,
    output logic [csa_tree_pkg::csa_level_outputs(P_IN_N)-1:0][P_WIDTH-1:0] o_ops
);

    import csa_tree_pkg::*;

    localparam int GROUPS = P_IN_N / 3;
    localparam int REST   = P_IN_N % 3;
    localparam int OUT_N  = csa_level_outputs(P_IN_N);

    logic [OUT_N-1:0][P_WIDTH-1:0] w_next;

    ////////////////////////////////////////////////////////////////////////////
    // Compressors
    ////////////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < GROUPS; g++) begin : g_csa
        logic [P_WIDTH-1:0] w_a;
        logic [P_WIDTH-1:0] w_b;
        logic [P_WIDTH-1:0] w_c;
        logic [P_WIDTH-1:0] w_maj;

        assign w_a   = i_ops[3*g];
        assign w_b   = i_ops[3*g+1];
        assign w_c   = i_ops[3*g+2];
        assign w_maj = (w_a & w_b) | (w_a & w_c) | (w_b & w_c);

        assign w_next[2*g]   = w_a ^ w_b ^ w_c;  // Bitwise sum
        assign w_next[2*g+1] = w_maj << 1;       // Carry moves one bit up
    end

    // Leftover operands go down unchanged
    for (genvar r = 0; r < REST; r++) begin : g_pass
        assign w_next[2*GROUPS+r] = i_ops[3*GROUPS+r];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Level register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ops <= '0;
        end else begin
            o_ops <= w_next;
        end
    end

endmodule

`default_nettype wire

// File: csa_reduce_tree.sv
`default_nettype none

// Chain of 3:2 levels, reduces P_IN_N words to a sum and a carry word
module csa_reduce_tree #(
    parameter int P_WIDTH = 8,
    parameter int P_IN_N  = 4
) (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic [P_IN_N-1:0][P_WIDTH-1:0] i_ops,
    output logic [P_WIDTH-1:0]            o_sum,
    output logic [P_WIDTH-1:0]            o_carry
);

    import csa_tree_pkg::*;

    localparam int STAGES = csa_stage_count(P_IN_N);

    // Word count entering level k
    function automatic int ops_at(input int k);
        int n;
        n = P_IN_N;
        for (int i = 0; i < k; i++) begin
            n = csa_level_outputs(n);
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Level chain
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < STAGES; k++) begin : g_lvl
        localparam int IN_N  = ops_at(k);
        localparam int OUT_N = csa_level_outputs(IN_N);

        logic [IN_N-1:0][P_WIDTH-1:0]  w_in;
        logic [OUT_N-1:0][P_WIDTH-1:0] w_out;

        if (k == 0) begin : g_first
            assign w_in = i_ops;
        end else begin : g_next
            assign w_in = g_lvl[k-1].w_out;  // Previous level feeds this one
        end

        csa_level #(
            .P_WIDTH (P_WIDTH),
            .P_IN_N  (IN_N)
        ) u_level (
            .clk   (clk),
            .i_rst (i_rst),
            .i_ops (w_in),
            .o_ops (w_out)
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Final pair
    ////////////////////////////////////////////////////////////////////////////

    if (STAGES == 0) begin : g_bypass
        // Two operands are already a sum and carry pair
        assign o_sum   = i_ops[0];
        assign o_carry = i_ops[1];
    end else begin : g_tail
        assign o_sum   = g_lvl[STAGES-1].w_out[0];
        assign o_carry = g_lvl[STAGES-1].w_out[1];
    end

endmodule

`default_nettype wire

// File: csa_merge.sv
`default_nettype none

// Joins the two trees, 4:2 compression then a registered final add
module csa_merge #(
    parameter int P_WIDTH = 11
) (
    input  logic               clk,
    input  logic               i_rst,
    input  logic [P_WIDTH-1:0] i_lo_sum,
    input  logic [P_WIDTH-1:0] i_lo_carry,
    input  logic [P_WIDTH-1:0] i_hi_sum,
    input  logic [P_WIDTH-1:0] i_hi_carry,
    output logic [P_WIDTH-1:0] o_data
);

    logic [P_WIDTH-1:0] w_s1;
    logic [P_WIDTH-1:0] w_c1;
    logic [P_WIDTH-1:0] w_s2;
    logic [P_WIDTH-1:0] w_c2;
    logic [P_WIDTH-1:0] r_sum;
    logic [P_WIDTH-1:0] r_carry;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1, two chained 3:2 compressors
    ////////////////////////////////////////////////////////////////////////////

    assign w_s1 = i_lo_sum ^ i_lo_carry ^ i_hi_sum;
    assign w_c1 = ((i_lo_sum & i_lo_carry)
                 | (i_lo_sum & i_hi_sum)
                 | (i_lo_carry & i_hi_sum)) << 1;

    // Fourth word joins here
    assign w_s2 = w_s1 ^ w_c1 ^ i_hi_carry;
    assign w_c2 = ((w_s1 & w_c1)
                 | (w_s1 & i_hi_carry)
                 | (w_c1 & i_hi_carry)) << 1;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            r_sum   <= '0;
            r_carry <= '0;
        end else begin
            r_sum   <= w_s2;
            r_carry <= w_c2;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2, carry-propagate add
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_data <= '0;
        end else begin
            o_data <= r_sum + r_carry;  // Wraps only above the true total
        end
    end

endmodule

`default_nettype wire

// File: csa_tree_top.sv
`default_nettype none

// Pipelined carry-save adder tree, two half trees and a merge block
module csa_tree_top #(
    parameter int  I_DATA_W = csa_tree_pkg::DEF_DATA_W,
    parameter int  I_DATA_N = csa_tree_pkg::DEF_DATA_N,  // Even
    localparam int O_DATA_W = csa_tree_pkg::csa_out_width(I_DATA_W, I_DATA_N)
) (
    input  logic                                 clk,
    input  logic                                 i_rst,
    input  logic [0:I_DATA_N-1][I_DATA_W-1:0]    i_data,
    output logic [O_DATA_W-1:0]                  o_data
);

    localparam int HALF_N = I_DATA_N / 2;

    logic [HALF_N-1:0][O_DATA_W-1:0] w_lo_ops;
    logic [HALF_N-1:0][O_DATA_W-1:0] w_hi_ops;
    logic [O_DATA_W-1:0]             w_lo_sum;
    logic [O_DATA_W-1:0]             w_lo_carry;
    logic [O_DATA_W-1:0]             w_hi_sum;
    logic [O_DATA_W-1:0]             w_hi_carry;

    ////////////////////////////////////////////////////////////////////////////
    // Operand split, zero extended to the result width
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < HALF_N; i++) begin : g_split
        assign w_lo_ops[i] = O_DATA_W'(i_data[i]);
        assign w_hi_ops[i] = O_DATA_W'(i_data[HALF_N+i]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Trees and merge
    ////////////////////////////////////////////////////////////////////////////

    csa_reduce_tree #(
        .P_WIDTH (O_DATA_W),
        .P_IN_N  (HALF_N)
    ) lo_tree (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_ops   (w_lo_ops),
        .o_sum   (w_lo_sum),
        .o_carry (w_lo_carry)
    );

    csa_reduce_tree #(
        .P_WIDTH (O_DATA_W),
        .P_IN_N  (HALF_N)
    ) hi_tree (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_ops   (w_hi_ops),
        .o_sum   (w_hi_sum),
        .o_carry (w_hi_carry)
    );

    csa_merge #(
        .P_WIDTH (O_DATA_W)
    ) merge (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_lo_sum   (w_lo_sum),
        .i_lo_carry (w_lo_carry),
        .i_hi_sum   (w_hi_sum),
        .i_hi_carry (w_hi_carry),
        .o_data     (o_data)
    );

endmodule

`default_nettype wire

// File: tb_csa_tree.sv
`default_nettype none

// Self-checking testbench for the carry-save adder tree
module tb_csa_tree;

    timeunit 1ns;
    timeprecision 1ps;

    import csa_tree_pkg::*;

    localparam int W          = DEF_DATA_W;
    localparam int N          = DEF_DATA_N;
    localparam int HALF       = N / 2;
    localparam int O_W        = csa_out_width(W, N);
    localparam int LAT        = csa_stage_count(N / 2) + MERGE_STAGES;
    localparam int CLK_PERIOD = 20;

    localparam int RST_CYCLES = 4;
    localparam int N_ISO      = 16;   // Vectors per half
    localparam int N_STREAM   = 200;
    localparam int N_PRE      = 20;   // Vectors before the mid-stream reset
    localparam int MID_RST    = 3;
    localparam int N_POST     = 20;

    localparam int TOTAL_VEC = RST_CYCLES + LAT + 2 + 2 * N_ISO + N_STREAM
                             + N_PRE + MID_RST + N_POST + LAT + 1;
    localparam int WATCHDOG_NS = TOTAL_VEC * CLK_PERIOD + 40 * CLK_PERIOD;

    // Lowest number of compared outputs for a complete run
    localparam int MIN_CHECKS = TOTAL_VEC - 2 * LAT;

    typedef logic [0:N-1][W-1:0] vec_t;

    logic           clk = 1'b0;
    logic           i_rst;
    vec_t           i_data;
    logic [O_W-1:0] o_data;

    int    seed = 9;
    string cur_test = "reset";

    // Index LAT-1 holds the result due at the next rising edge
    logic [O_W-1:0] exp_pipe [LAT];
    string          name_pipe [LAT];
    bit             primed = 1'b0;
    int             n_checked = 0;

    csa_tree_top UUT (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_data (i_data),
        .o_data (o_data)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic vec_t random_vector();
        vec_t v;
        for (int i = 0; i < N; i++) begin
            v[i] = W'($random(seed));
        end
        return v;
    endfunction

    function automatic logic [W-1:0] nonzero_operand();
        logic [W-1:0] w;
        w = W'($random(seed));
        if (w == '0) begin
            w = W'(1);
        end
        return w;
    endfunction

    // Random nonzero words in one half and zeros in the other
    function automatic vec_t half_vector(input bit upper);
        vec_t v;
        v = '0;
        for (int i = 0; i < HALF; i++) begin
            if (upper) begin
                v[HALF+i] = nonzero_operand();
            end else begin
                v[i] = nonzero_operand();
            end
        end
        return v;
    endfunction

    function automatic vec_t filled_vector(input logic [W-1:0] word);
        vec_t v;
        for (int i = 0; i < N; i++) begin
            v[i] = word;
        end
        return v;
    endfunction

    task automatic apply_vector(input string name, input vec_t v);
        @(negedge clk);
        i_rst    = 1'b0;
        i_data   = v;
        cur_test = name;
    endtask

    // Reset with random data on the bus
    task automatic pulse_reset(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            i_rst    = 1'b1;
            i_data   = random_vector();
            cur_test = name;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and output check
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [O_W-1:0] sum_ops(input vec_t v);
        logic [O_W-1:0] acc;
        acc = '0;
        for (int i = 0; i < N; i++) begin
            acc = acc + O_W'(v[i]);
        end
        return acc;
    endfunction

    always @(posedge clk) begin
        if (primed) begin
            assert (o_data === exp_pipe[LAT-1]) else begin
                $display("Mismatch %s: expected %0d, actual %0d",
                         name_pipe[LAT-1], exp_pipe[LAT-1], o_data);
                $display("SOME TESTS FAILED");
                $fatal(1, "output compare failed");
            end
            n_checked = n_checked + 1;
        end

        for (int k = LAT - 1; k > 0; k--) begin
            exp_pipe[k]  = exp_pipe[k-1];
            name_pipe[k] = name_pipe[k-1];
        end

        if (i_rst) begin
            // Every pipeline register clears so nothing stays in flight
            for (int k = 0; k < LAT; k++) begin
                exp_pipe[k]  = '0;
                name_pipe[k] = cur_test;
            end
            primed = 1'b1;
        end else begin
            exp_pipe[0]  = sum_ops(i_data);
            name_pipe[0] = cur_test;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        i_rst  = 1'b1;
        i_data = random_vector();  // Nonzero data while in reset

        pulse_reset("reset", RST_CYCLES - 1);

        // Outputs stay zero while the first vectors travel
        for (int i = 0; i < LAT; i++) begin
            apply_vector("reset", random_vector());
        end

        apply_vector("all_zero", filled_vector('0));
        apply_vector("all_max", filled_vector('1));

        for (int i = 0; i < N_ISO; i++) begin
            apply_vector("lower_half", half_vector(1'b0));
        end
        for (int i = 0; i < N_ISO; i++) begin
            apply_vector("upper_half", half_vector(1'b1));
        end

        for (int i = 0; i < N_STREAM; i++) begin
            apply_vector("stream", random_vector());
        end

        for (int i = 0; i < N_PRE; i++) begin
            apply_vector("reset_mid_stream", random_vector());
        end
        pulse_reset("reset_mid_stream", MID_RST);
        for (int i = 0; i < N_POST; i++) begin
            apply_vector("reset_mid_stream", random_vector());
        end

        // Drain the pipeline
        for (int i = 0; i < LAT + 1; i++) begin
            apply_vector("drain", '0);
        end
        @(negedge clk);

        if (n_checked >= MIN_CHECKS) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Only %0d outputs were compared, expected at least %0d",
                     n_checked, MIN_CHECKS);
            $display("SOME TESTS FAILED");
            $fatal(1, "too few compares");
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the run hung before all tests ended",
                 WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: csa_tree.f
csa_tree_pkg.sv
csa_level.sv
csa_reduce_tree.sv
csa_merge.sv
csa_tree_top.sv
tb_csa_tree.sv

// File: Makefile
# Verilator simulation of the carry-save adder tree

TOP = tb_csa_tree

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f csa_tree.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
